//--- Bender.yml
package:
  name: master_axi_async

sources:
  - include_dirs:
      - src
    files:
      - src/axi_cdc_pkg.sv
      - src/fifo_rw_if.sv
      - src/async_fifo_core.sv
      - src/cdc_channel.sv
      - src/master_axi_async.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_master_axi_async.sv

//--- compile.f
+incdir+src
src/axi_cdc_pkg.sv
src/fifo_rw_if.sv
src/async_fifo_core.sv
src/cdc_channel.sv
src/master_axi_async.sv
testbench/tb_master_axi_async.sv

//--- src/async_fifo_core.sv
`timescale 1ns/1ps
`include "axi_cdc_consts.svh"

module async_fifo_core (
    input logic wr_clk,
    input logic wr_rst,
    input logic rd_clk,
    input logic rd_rst,
    fifo_rw_if.core port
);
    localparam int WIDTH = $bits(port.wr_data);
    localparam int AW = `CDC_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;
    localparam int STAGES = `CDC_SYNC_STAGES;

    logic [WIDTH-1:0] mem [DEPTH];

    // Pointers carry one extra wrap bit
    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray;
    logic [AW:0] wr_gray_next;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray;
    logic [AW:0] rd_gray_next;

    // Read pointer seen from the write clock, and the reverse
    logic [AW:0] rd_gray_sync [STAGES];
    logic [AW:0] wr_gray_sync [STAGES];

    assign wr_bin_next = wr_bin + {{AW{1'b0}}, port.wr_en};
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);
    assign rd_bin_next = rd_bin + {{AW{1'b0}}, port.rd_en};
    assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

    // Write domain
    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_bin <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin <= wr_bin_next;
            wr_gray <= wr_gray_next;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (port.wr_en) begin
            mem[wr_bin[AW-1:0]] <= port.wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            for (int i = 0; i < STAGES; i++) begin
                rd_gray_sync[i] <= '0;
            end
        end else begin
            rd_gray_sync[0] <= rd_gray;
            for (int i = 1; i < STAGES; i++) begin
                rd_gray_sync[i] <= rd_gray_sync[i-1];
            end
        end
    end

    // Full when the top two Gray bits differ and the rest match
    assign port.full = (wr_gray == {~rd_gray_sync[STAGES-1][AW:AW-1],
                                    rd_gray_sync[STAGES-1][AW-2:0]});

    // Read domain
    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bin <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin <= rd_bin_next;
            rd_gray <= rd_gray_next;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            for (int i = 0; i < STAGES; i++) begin
                wr_gray_sync[i] <= '0;
            end
        end else begin
            wr_gray_sync[0] <= wr_gray;
            for (int i = 1; i < STAGES; i++) begin
                wr_gray_sync[i] <= wr_gray_sync[i-1];
            end
        end
    end

    assign port.empty = (rd_gray == wr_gray_sync[STAGES-1]);

    // Head word is visible before it is popped
    assign port.rd_data = mem[rd_bin[AW-1:0]];

    // Handshake logic above must respect the flags
    wr_no_overflow: assert property (
        @(posedge wr_clk) disable iff (wr_rst) port.wr_en |-> !port.full
    ) else $error("write into full FIFO");

    rd_no_underflow: assert property (
        @(posedge rd_clk) disable iff (rd_rst) port.rd_en |-> !port.empty
    ) else $error("read from empty FIFO");

endmodule

//--- src/axi_cdc_consts.svh
`ifndef AXI_CDC_CONSTS_SVH
`define AXI_CDC_CONSTS_SVH

// Bus field widths
`define AXI_ADDR_W 32
`define AXI_LEN_W 8
`define AXI_ID_W 2
`define AXI_DATA_W 32
`define AXI_STRB_W 4

// Crossing FIFO geometry, 16 entries
`define CDC_DEPTH_LOG2 4
`define CDC_SYNC_STAGES 2
`endif

//--- src/axi_cdc_pkg.sv
`include "axi_cdc_consts.svh"

package axi_cdc_pkg;

    // Write or read address request, 42 bits
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0] len;
        logic [`AXI_ID_W-1:0] id;
    } addr_req_t;

    // Write data beat, master to bus, 39 bits
    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic [`AXI_STRB_W-1:0] strb;
        logic last;
        logic [`AXI_DATA_W-1:0] data;
    } wr_beat_t;

    // Read data beat, bus to master, 35 bits
    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic last;
        logic [`AXI_DATA_W-1:0] data;
    } rd_beat_t;

endpackage

//--- src/cdc_channel.sv
`timescale 1ns/1ps

module cdc_channel #(
    parameter int WIDTH = 8
) (
    input logic src_clk,
    input logic src_rst,
    input logic src_valid,
    output logic src_ready,
    input logic [WIDTH-1:0] src_data,

    input logic dst_clk,
    input logic dst_rst,
    input logic dst_ready,
    output logic dst_valid,
    output logic [WIDTH-1:0] dst_data
);
    logic occupied;
    logic take;

    fifo_rw_if #(.WIDTH(WIDTH)) fifo_port ();

    async_fifo_core fifo_core (
        .wr_clk (src_clk),
        .wr_rst (src_rst),
        .rd_clk (dst_clk),
        .rd_rst (dst_rst),
        .port   (fifo_port.core)
    );

    // Source side, push on every handshake
    assign src_ready = !fifo_port.full && !src_rst;
    assign fifo_port.wr_en = src_valid && src_ready;
    assign fifo_port.wr_data = src_data;

    // Output stage refills when empty or when its word leaves
    assign take = occupied && dst_ready;
    assign fifo_port.rd_en = !fifo_port.empty && (!occupied || take);

    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            occupied <= 1'b0;
        end else if (fifo_port.rd_en) begin
            occupied <= 1'b1;
        end else if (take) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge dst_clk) begin
        if (fifo_port.rd_en) begin
            dst_data <= fifo_port.rd_data;
        end
    end

    assign dst_valid = occupied;

    // Stalled word must not change or drop
    hold_while_stalled: assert property (
        @(posedge dst_clk) disable iff (dst_rst)
        dst_valid && !dst_ready |=> dst_valid && $stable(dst_data)
    ) else $error("output word changed while stalled");

endmodule

//--- src/fifo_rw_if.sv
`timescale 1ns/1ps

interface fifo_rw_if #(
    parameter int WIDTH = 8
);
    // Write side, source clock
    logic wr_en;
    logic [WIDTH-1:0] wr_data;
    logic full;

    // Read side, destination clock
    logic rd_en;
    logic [WIDTH-1:0] rd_data;
    logic empty;

    modport user (
        output wr_en, wr_data, rd_en,
        input full, rd_data, empty
    );

    modport core (
        input wr_en, wr_data, rd_en,
        output full, rd_data, empty
    );

endinterface

//--- src/master_axi_async.sv
`timescale 1ns/1ps
`include "axi_cdc_consts.svh"

module master_axi_async (
    input logic BUS_CLK,
    input logic BUS_RST,
    input logic MASTER_CLK,
    input logic MASTER_RST,

    // Bus side
    output logic [`AXI_ADDR_W-1:0] bus_wr_addr,
    output logic [`AXI_LEN_W-1:0] bus_wr_len,
    output logic [`AXI_ID_W-1:0] bus_wr_id,
    output logic bus_wr_addr_valid,
    input logic bus_wr_addr_ready,

    output logic [`AXI_DATA_W-1:0] bus_wr_data,
    output logic [`AXI_STRB_W-1:0] bus_wr_strb,
    output logic [`AXI_ID_W-1:0] bus_wr_back_id,
    output logic bus_wr_data_valid,
    input logic bus_wr_data_ready,
    output logic bus_wr_data_last,

    output logic [`AXI_ADDR_W-1:0] bus_rd_addr,
    output logic [`AXI_LEN_W-1:0] bus_rd_len,
    output logic [`AXI_ID_W-1:0] bus_rd_id,
    output logic bus_rd_addr_valid,
    input logic bus_rd_addr_ready,

    input logic [`AXI_DATA_W-1:0] bus_rd_data,
    input logic [`AXI_ID_W-1:0] bus_rd_back_id,
    input logic bus_rd_data_last,
    output logic bus_rd_data_ready,
    input logic bus_rd_data_valid,

    // Master side
    input logic [`AXI_ADDR_W-1:0] master_wr_addr,
    input logic [`AXI_LEN_W-1:0] master_wr_len,
    input logic [`AXI_ID_W-1:0] master_wr_id,
    input logic master_wr_addr_valid,
    output logic master_wr_addr_ready,

    input logic [`AXI_DATA_W-1:0] master_wr_data,
    input logic [`AXI_STRB_W-1:0] master_wr_strb,
    input logic [`AXI_ID_W-1:0] master_wr_back_id,
    input logic master_wr_data_valid,
    output logic master_wr_data_ready,
    input logic master_wr_data_last,

    input logic [`AXI_ADDR_W-1:0] master_rd_addr,
    input logic [`AXI_LEN_W-1:0] master_rd_len,
    input logic [`AXI_ID_W-1:0] master_rd_id,
    input logic master_rd_addr_valid,
    output logic master_rd_addr_ready,

    output logic [`AXI_DATA_W-1:0] master_rd_data,
    output logic [`AXI_ID_W-1:0] master_rd_back_id,
    output logic master_rd_data_last,
    input logic master_rd_data_ready,
    output logic master_rd_data_valid
);
    import axi_cdc_pkg::*;

    addr_req_t wr_addr_in;
    addr_req_t wr_addr_out;
    addr_req_t rd_addr_in;
    addr_req_t rd_addr_out;
    wr_beat_t wr_beat_in;
    wr_beat_t wr_beat_out;
    rd_beat_t rd_beat_in;
    rd_beat_t rd_beat_out;

    // Pack source payloads
    assign wr_addr_in = '{addr: master_wr_addr, len: master_wr_len, id: master_wr_id};
    assign rd_addr_in = '{addr: master_rd_addr, len: master_rd_len, id: master_rd_id};
    assign wr_beat_in = '{id: master_wr_back_id, strb: master_wr_strb,
                          last: master_wr_data_last, data: master_wr_data};
    assign rd_beat_in = '{id: bus_rd_back_id, last: bus_rd_data_last, data: bus_rd_data};

    // Master to bus channels
    cdc_channel #(.WIDTH($bits(addr_req_t))) wr_addr_chan (
        .src_clk (MASTER_CLK), .src_rst (MASTER_RST),
        .src_valid (master_wr_addr_valid), .src_ready (master_wr_addr_ready),
        .src_data (wr_addr_in),
        .dst_clk (BUS_CLK), .dst_rst (BUS_RST),
        .dst_ready (bus_wr_addr_ready), .dst_valid (bus_wr_addr_valid),
        .dst_data (wr_addr_out)
    );

    cdc_channel #(.WIDTH($bits(addr_req_t))) rd_addr_chan (
        .src_clk (MASTER_CLK), .src_rst (MASTER_RST),
        .src_valid (master_rd_addr_valid), .src_ready (master_rd_addr_ready),
        .src_data (rd_addr_in),
        .dst_clk (BUS_CLK), .dst_rst (BUS_RST),
        .dst_ready (bus_rd_addr_ready), .dst_valid (bus_rd_addr_valid),
        .dst_data (rd_addr_out)
    );

    cdc_channel #(.WIDTH($bits(wr_beat_t))) wr_data_chan (
        .src_clk (MASTER_CLK), .src_rst (MASTER_RST),
        .src_valid (master_wr_data_valid), .src_ready (master_wr_data_ready),
        .src_data (wr_beat_in),
        .dst_clk (BUS_CLK), .dst_rst (BUS_RST),
        .dst_ready (bus_wr_data_ready), .dst_valid (bus_wr_data_valid),
        .dst_data (wr_beat_out)
    );

    // Read data runs the other way, bus to master
    cdc_channel #(.WIDTH($bits(rd_beat_t))) rd_data_chan (
        .src_clk (BUS_CLK), .src_rst (BUS_RST),
        .src_valid (bus_rd_data_valid), .src_ready (bus_rd_data_ready),
        .src_data (rd_beat_in),
        .dst_clk (MASTER_CLK), .dst_rst (MASTER_RST),
        .dst_ready (master_rd_data_ready), .dst_valid (master_rd_data_valid),
        .dst_data (rd_beat_out)
    );

    // Unpack destination payloads
    assign bus_wr_addr = wr_addr_out.addr;
    assign bus_wr_len = wr_addr_out.len;
    assign bus_wr_id = wr_addr_out.id;
    assign bus_rd_addr = rd_addr_out.addr;
    assign bus_rd_len = rd_addr_out.len;
    assign bus_rd_id = rd_addr_out.id;
    assign bus_wr_back_id = wr_beat_out.id;
    assign bus_wr_strb = wr_beat_out.strb;
    assign bus_wr_data_last = wr_beat_out.last;
    assign bus_wr_data = wr_beat_out.data;
    assign master_rd_back_id = rd_beat_out.id;
    assign master_rd_data_last = rd_beat_out.last;
    assign master_rd_data = rd_beat_out.data;

endmodule

//--- testbench/tb_master_axi_async.sv
`timescale 1ns/1ps
`include "axi_cdc_consts.svh"

module tb_master_axi_async;
    import axi_cdc_pkg::*;

    localparam int WORD_W = $bits(addr_req_t);
    localparam int WAIT_LIMIT = 400;
    localparam int PAT_LEN = 256;
    localparam int BURST = 20;
    localparam int N_STIM = 12;
    localparam int STALL_CYCLES = 32;

    // Kind 0 write address, 1 read address, 2 write data, 3 read data
    typedef struct packed {
        logic [1:0] kind;
        logic [WORD_W-1:0] payload;
    } stim_t;

    logic BUS_CLK;
    logic BUS_RST;
    logic MASTER_CLK;
    logic MASTER_RST;
    // Handshake bits indexed by channel kind
    logic [3:0] src_valid;
    wire [3:0] src_ready;
    wire [3:0] dst_valid;
    logic [3:0] dst_ready;
    addr_req_t master_wa;
    addr_req_t master_ra;
    wr_beat_t master_wd;
    rd_beat_t bus_rd;
    wire addr_req_t bus_wa;
    wire addr_req_t bus_ra;
    wire wr_beat_t bus_wd;
    wire rd_beat_t master_rd;

    stim_t stim_table [N_STIM];
    logic [WORD_W-1:0] send_q [4][$];
    logic [WORD_W-1:0] exp_q [4][$];
    logic [3:0] ready_pat [PAT_LEN];
    integer seed;
    int mismatch_count;
    int timeout_count;
    logic hold_wr_data;

    master_axi_async master_axi_async_inst (
        .BUS_CLK (BUS_CLK), .BUS_RST (BUS_RST),
        .MASTER_CLK (MASTER_CLK), .MASTER_RST (MASTER_RST),
        .bus_wr_addr (bus_wa.addr), .bus_wr_len (bus_wa.len), .bus_wr_id (bus_wa.id),
        .bus_wr_addr_valid (dst_valid[0]), .bus_wr_addr_ready (dst_ready[0]),
        .bus_wr_data (bus_wd.data), .bus_wr_strb (bus_wd.strb),
        .bus_wr_back_id (bus_wd.id), .bus_wr_data_last (bus_wd.last),
        .bus_wr_data_valid (dst_valid[2]), .bus_wr_data_ready (dst_ready[2]),
        .bus_rd_addr (bus_ra.addr), .bus_rd_len (bus_ra.len), .bus_rd_id (bus_ra.id),
        .bus_rd_addr_valid (dst_valid[1]), .bus_rd_addr_ready (dst_ready[1]),
        .bus_rd_data (bus_rd.data), .bus_rd_back_id (bus_rd.id),
        .bus_rd_data_last (bus_rd.last),
        .bus_rd_data_valid (src_valid[3]), .bus_rd_data_ready (src_ready[3]),
        .master_wr_addr (master_wa.addr), .master_wr_len (master_wa.len),
        .master_wr_id (master_wa.id),
        .master_wr_addr_valid (src_valid[0]), .master_wr_addr_ready (src_ready[0]),
        .master_wr_data (master_wd.data), .master_wr_strb (master_wd.strb),
        .master_wr_back_id (master_wd.id), .master_wr_data_last (master_wd.last),
        .master_wr_data_valid (src_valid[2]), .master_wr_data_ready (src_ready[2]),
        .master_rd_addr (master_ra.addr), .master_rd_len (master_ra.len),
        .master_rd_id (master_ra.id),
        .master_rd_addr_valid (src_valid[1]), .master_rd_addr_ready (src_ready[1]),
        .master_rd_data (master_rd.data), .master_rd_back_id (master_rd.id),
        .master_rd_data_last (master_rd.last),
        .master_rd_data_valid (dst_valid[3]), .master_rd_data_ready (dst_ready[3])
    );

    always #20 BUS_CLK = ~BUS_CLK;
    always #14 MASTER_CLK = ~MASTER_CLK;

    // Every word crosses unchanged, so each payload is also its expected word
    task automatic load_table();
        stim_table[0] = '{2'd0, WORD_W'({32'h1000_0040, 8'd3, 2'd1})};
        stim_table[1] = '{2'd1, WORD_W'({32'h2000_0100, 8'd0, 2'd0})};
        stim_table[2] = '{2'd2, WORD_W'({2'd1, 4'hf, 1'b0, 32'hcafe_0001})};
        stim_table[3] = '{2'd3, WORD_W'({2'd0, 1'b0, 32'h5eed_0001})};
        stim_table[4] = '{2'd2, WORD_W'({2'd1, 4'h3, 1'b1, 32'hcafe_0002})};
        stim_table[5] = '{2'd0, WORD_W'({32'h1000_0080, 8'd1, 2'd2})};
        stim_table[6] = '{2'd3, WORD_W'({2'd3, 1'b1, 32'hdead_beef})};
        stim_table[7] = '{2'd1, WORD_W'({32'h2000_0200, 8'd7, 2'd3})};
        stim_table[8] = '{2'd0, WORD_W'({32'hffff_fffc, 8'hff, 2'd3})};
        stim_table[9] = '{2'd2, WORD_W'({2'd2, 4'h1, 1'b1, 32'h1234_5678})};
        stim_table[10] = '{2'd3, WORD_W'({2'd1, 1'b0, 32'h0bad_f00d})};
        stim_table[11] = '{2'd1, WORD_W'({32'h8000_0004, 8'd15, 2'd1})};
    endtask

    task automatic check_addr(input string what, input addr_req_t got, input addr_req_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %p, expected %p", $time, what, got, want);
        end
    endtask

    task automatic check_wr_beat(input string what, input wr_beat_t got, input wr_beat_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %p, expected %p", $time, what, got, want);
        end
    endtask

    task automatic check_rd_beat(input string what, input rd_beat_t got, input rd_beat_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %p, expected %p", $time, what, got, want);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic tick(input bit on_bus, input bit falling);
        if (on_bus && falling)
            @(negedge BUS_CLK);
        else if (on_bus)
            @(posedge BUS_CLK);
        else if (falling)
            @(negedge MASTER_CLK);
        else
            @(posedge MASTER_CLK);
    endtask

    task automatic drive_src(input int kind, input logic [WORD_W-1:0] word);
        case (kind)
            0: master_wa = word;
            1: master_ra = word;
            2: master_wd = word[$bits(wr_beat_t)-1:0];
            default: bus_rd = word[$bits(rd_beat_t)-1:0];
        endcase
    endtask

    // Returns on the source edge where ready is seen high
    task automatic wait_src_ready(input int kind);
        int waited;
        waited = 0;
        do begin
            tick(kind == 3, 1'b0);
            waited++;
        end while (!src_ready[kind] && waited < WAIT_LIMIT);
        if (!src_ready[kind]) begin
            timeout_count++;
            $display("Timeout: source ready of channel %0d stayed low", kind);
        end
    endtask

    task automatic send_words(input int kind);
        while (send_q[kind].size() > 0) begin
            tick(kind == 3, 1'b1);
            drive_src(kind, send_q[kind].pop_front());
            src_valid[kind] = 1'b1;
            wait_src_ready(kind);
        end
        tick(kind == 3, 1'b1);
        src_valid[kind] = 1'b0;
    endtask

    task automatic collect_words(input int kind);
        int idle;
        int n;
        logic ready;
        logic [WORD_W-1:0] want;
        idle = 0;
        n = 0;
        while (exp_q[kind].size() > 0 && idle < WAIT_LIMIT) begin
            tick(kind != 3, 1'b1);
            ready = ready_pat[n % PAT_LEN][kind] && !(kind == 2 && hold_wr_data);
            dst_ready[kind] = ready;
            n++;
            tick(kind != 3, 1'b0);
            if (dst_valid[kind] && ready) begin
                want = exp_q[kind].pop_front();
                idle = 0;
                case (kind)
                    0: check_addr("write address", bus_wa, want);
                    1: check_addr("read address", bus_ra, want);
                    2: check_wr_beat("write data", bus_wd, want[$bits(wr_beat_t)-1:0]);
                    default: check_rd_beat("read data", master_rd, want[$bits(rd_beat_t)-1:0]);
                endcase
            end else begin
                idle++;
            end
        end
        if (exp_q[kind].size() > 0) begin
            timeout_count++;
            $display("Timeout: channel %0d still owes %0d words", kind, exp_q[kind].size());
        end
        tick(kind != 3, 1'b1);
        dst_ready[kind] = 1'b0;
    endtask

    // FIFO plus output stage absorb the stalled beats
    task automatic watch_backpressure();
        int accepted;
        int stalled;
        int waited;
        accepted = 0;
        stalled = 0;
        waited = 0;
        while (stalled < STALL_CYCLES && waited < WAIT_LIMIT) begin
            @(posedge MASTER_CLK);
            waited++;
            if (src_valid[2] && src_ready[2]) begin
                accepted++;
                stalled = 0;
            end else if (src_valid[2]) begin
                stalled++;
            end
        end
        if (stalled < STALL_CYCLES) begin
            timeout_count++;
            $display("Timeout: write data ready never stayed low under back-pressure");
        end
        check_value("beats accepted under back-pressure", accepted, (1 << `CDC_DEPTH_LOG2) + 1);
        hold_wr_data = 1'b0;
    endtask

    initial begin
        seed = 32'h651d7383;
        mismatch_count = 0;
        timeout_count = 0;
        hold_wr_data = 1'b0;
        BUS_CLK = 1'b0;
        MASTER_CLK = 1'b0;
        BUS_RST = 1'b1;
        MASTER_RST = 1'b1;
        src_valid = '0;
        dst_ready = '0;
        master_wa = '0;
        master_ra = '0;
        master_wd = '0;
        bus_rd = '0;
        for (int i = 0; i < PAT_LEN; i++) begin
            ready_pat[i] = $random(seed);
        end
        load_table();

        fork
            begin
                repeat (4) @(negedge BUS_CLK);
                check_value("bus side valids in reset", dst_valid[2:0], 0);
                check_value("bus side ready in reset", src_ready[3], 0);
                BUS_RST = 1'b0;
            end
            begin
                repeat (4) @(negedge MASTER_CLK);
                check_value("master side valid in reset", dst_valid[3], 0);
                check_value("master side readies in reset", src_ready[2:0], 0);
                MASTER_RST = 1'b0;
            end
        join
        for (int k = 0; k < 4; k++) begin
            wait_src_ready(k);
        end

        // All four channels at once, random consumer stalls
        for (int i = 0; i < N_STIM; i++) begin
            send_q[stim_table[i].kind].push_back(stim_table[i].payload);
            exp_q[stim_table[i].kind].push_back(stim_table[i].payload);
        end
        fork
            send_words(0);
            send_words(1);
            send_words(2);
            send_words(3);
            collect_words(0);
            collect_words(1);
            collect_words(2);
            collect_words(3);
        join

        // Write data burst against a stalled bus
        hold_wr_data = 1'b1;
        for (int i = 0; i < BURST; i++) begin
            send_q[2].push_back(WORD_W'({2'(i), 4'(i), i == BURST - 1, 32'h00b0_0000 + i}));
            exp_q[2].push_back(send_q[2][i]);
        end
        fork
            send_words(2);
            collect_words(2);
            watch_backpressure();
        join
        repeat (8) @(posedge BUS_CLK);
        check_value("write data valid after the burst drained", dst_valid[2], 0);

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
